// ==== include/sata_transport_macros.svh ====
// SATA transport constants
`ifndef SATA_TRANSPORT_MACROS_SVH
`define SATA_TRANSPORT_MACROS_SVH

// FIS type codes, low byte of the first dword
`define ST_FIS_H2D_REG      8'h27
`define ST_FIS_D2H_REG      8'h34
`define ST_FIS_DMA_ACT      8'h39
`define ST_FIS_SET_DEV_BITS 8'hA1

// Length of the outgoing register FIS, also the link write size
`define ST_H2D_REG_DWORDS   5

// Link dword width
`define ST_DWORD_W          32

// Logical block address width
`define ST_LBA_W            48

// Dword position within a frame
`define ST_IDX_W            3

`endif

// ==== rtl/sata_transport_pkg.sv ====
// SATA transport types
`default_nettype none

`include "sata_transport_macros.svh"

package sata_transport_pkg;

  typedef logic [`ST_DWORD_W-1:0] dword_t;
  typedef logic [7:0]             fis_type_t;
  typedef logic [`ST_LBA_W-1:0]   lba_t;
  typedef logic [15:0]            sector_count_t;
  typedef logic [`ST_IDX_W-1:0]   dword_idx_t;

  typedef enum logic [2:0] {
    IDLE,
    CHECK_FIS_TYPE,
    WRITE_H2D_REG,
    RETRY,
    READ_D2H_REG,
    FINISH_SDB,
    FINISH_DMA_ACT
  } ctrl_state_t;

  // Tells the parser which register frame is on the link
  typedef enum logic [1:0] {
    NONE,
    D2H_REG,
    SET_DEV_BITS
  } fis_kind_t;

  typedef struct packed {
    logic [7:0]    command;
    logic [15:0]   features;
    logic [7:0]    control;
    logic [3:0]    port_mult;
    logic [7:0]    device;
    lba_t          lba;
    sector_count_t sector_count;
  } h2d_regs_t;

  typedef struct packed {
    logic          interrupt;
    logic          notification;
    logic [3:0]    port_mult;
    logic [7:0]    device;
    lba_t          lba;
    sector_count_t sector_count;
    logic [7:0]    status;
    logic [7:0]    error;
  } d2h_regs_t;

  // Transmit side toward the link layer
  typedef struct packed {
    logic   write_start;
    dword_t write_data;
    dword_t write_size;
  } ll_tx_t;

  typedef struct packed {
    logic write_strobe;
    logic write_finished;
    logic xmit_error;
  } ll_tx_status_t;

  // Receive side from the link layer
  typedef struct packed {
    logic   read_start;
    logic   read_strobe;
    logic   read_finished;
    dword_t read_data;
  } ll_rx_t;

endpackage

`default_nettype wire

// ==== rtl/fis_dword_counter.sv ====
// FIS dword counter
`default_nettype none
`timescale 1ns/1ps

module fis_dword_counter (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            clear,
  input  wire                            step,
  output sata_transport_pkg::dword_idx_t idx
);

  // Position of the next dword in the current frame
  always_ff @(posedge clk) begin
    if (rst) begin
      idx <= '0;
    end else if (clear) begin
      idx <= '0;
    end else if (step && (idx != '1)) begin
      // Holds at all ones on an overlong frame
      idx <= idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/h2d_fis_builder.sv ====
// Host to device register FIS builder
`default_nettype none
`timescale 1ns/1ps

`include "sata_transport_macros.svh"

module h2d_fis_builder (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                capture,
  input  wire                                cmd_bit,
  input  wire sata_transport_pkg::h2d_regs_t  h2d,
  input  wire sata_transport_pkg::dword_idx_t idx,
  output sata_transport_pkg::dword_t          write_data
);
  import sata_transport_pkg::*;

  h2d_regs_t regs_q;
  logic      cmd_q;

  // Snapshot at send start, host is free to change its registers afterwards
  always_ff @(posedge clk) begin
    if (capture) begin
      regs_q <= h2d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_q <= 1'b0;
    end else if (capture) begin
      cmd_q <= cmd_bit;
    end
  end

  // Register FIS layout, dword 4 and past the end read as zero
  always_comb begin
    case (idx)
      0: write_data = {regs_q.features[7:0], regs_q.command, cmd_q, 3'b000,
                       regs_q.port_mult, `ST_FIS_H2D_REG};
      1: write_data = {regs_q.device, regs_q.lba[23:0]};
      2: write_data = {regs_q.features[15:8], regs_q.lba[47:24]};
      3: write_data = {regs_q.control, 8'h00, regs_q.sector_count};
      default: write_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/d2h_fis_parser.sv ====
// Device to host register parser
`default_nettype none
`timescale 1ns/1ps

module d2h_fis_parser (
  input  wire                                clk,
  input  wire                                rst,
  input  wire sata_transport_pkg::ll_rx_t     rx,
  input  wire sata_transport_pkg::dword_idx_t idx,
  input  wire sata_transport_pkg::fis_kind_t  fis_kind,
  output sata_transport_pkg::d2h_regs_t       d2h
);
  import sata_transport_pkg::*;

  dword_t rd;

  assign rd = rx.read_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      d2h <= '0;
    end else if (rx.read_strobe) begin
      case (fis_kind)
        D2H_REG: begin
          case (idx)
            0: begin
              // Header dword carries status and error
              d2h.status    <= rd[23:16];
              d2h.error     <= rd[31:24];
              d2h.interrupt <= rd[14];
              d2h.port_mult <= rd[11:8];
            end
            1: begin
              d2h.device     <= rd[31:24];
              d2h.lba[23:0]  <= rd[23:0];
            end
            2: begin
              d2h.lba[47:24] <= rd[23:0];
            end
            3: begin
              d2h.sector_count <= rd[15:0];
            end
            default: begin
            end
          endcase
        end
        SET_DEV_BITS: begin
          // Only the header matters, bits 7 and 3 of status stay put
          if (idx == '0) begin
            d2h.status[6:4]  <= rd[22:20];
            d2h.status[2:0]  <= rd[18:16];
            d2h.error        <= rd[31:24];
            d2h.notification <= rd[15];
            d2h.interrupt    <= rd[14];
            d2h.port_mult    <= rd[11:8];
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/transport_ctrl_fsm.sv ====
// Transport control FSM
`default_nettype none
`timescale 1ns/1ps

`include "sata_transport_macros.svh"

module transport_ctrl_fsm (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   send_command_stb,
  input  wire                                   send_control_stb,
  input  wire                                   link_layer_ready,
  input  wire                                   sync_escape,
  input  wire                                   ll_remote_abort,
  input  wire sata_transport_pkg::ll_tx_status_t tx_status,
  input  wire sata_transport_pkg::ll_rx_t        rx,
  input  wire sata_transport_pkg::dword_idx_t    idx,
  output logic                                  cnt_clear,
  output logic                                  cnt_step,
  output logic                                  capture,
  output logic                                  cmd_bit,
  output logic                                  write_start,
  output sata_transport_pkg::fis_kind_t          fis_kind,
  output logic                                  d2h_reg_stb,
  output logic                                  set_device_bits_stb,
  output logic                                  dma_activate_stb,
  output logic                                  remote_abort,
  output logic                                  xmit_error,
  output logic                                  transport_layer_ready
);
  import sata_transport_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  fis_type_t   cur_type;
  fis_type_t   hdr_type;
  fis_type_t   frame_type;
  logic        hdr_seen;
  logic        hdr_cycle;
  logic        rx_active;
  logic        send_req;
  logic        resend;
  logic        write_done;
  logic        frame_end;

  function automatic fis_kind_t kind_of(input fis_type_t t);
    case (t)
      `ST_FIS_D2H_REG:      kind_of = D2H_REG;
      `ST_FIS_SET_DEV_BITS: kind_of = SET_DEV_BITS;
      default:              kind_of = NONE;
    endcase
  endfunction

  assign hdr_type   = rx.read_data[7:0];
  assign rx_active  = (state == CHECK_FIS_TYPE) || (state == READ_D2H_REG) ||
                      (state == FINISH_SDB) || (state == FINISH_DMA_ACT);
  // First strobed dword of a received frame
  assign hdr_cycle  = (state == CHECK_FIS_TYPE) && !hdr_seen && rx.read_strobe;
  assign frame_type = hdr_cycle ? hdr_type : cur_type;
  assign frame_end  = rx_active && rx.read_finished && (hdr_cycle || hdr_seen) && !sync_escape;
  assign send_req   = (state == IDLE) && (send_command_stb || send_control_stb);
  assign resend     = (state == RETRY) && link_layer_ready;
  assign write_done = (state == WRITE_H2D_REG) && tx_status.write_finished;

  assign capture   = send_req;
  assign cmd_bit   = send_command_stb;
  assign cnt_clear = (state == IDLE) || resend;
  // Transmit index stops at the frame length
  assign cnt_step  = ((state == WRITE_H2D_REG) && tx_status.write_strobe &&
                      (idx < dword_idx_t'(`ST_H2D_REG_DWORDS))) ||
                     (rx_active && rx.read_strobe);
  assign fis_kind  = rx_active ? kind_of(frame_type) : NONE;

  assign transport_layer_ready = (state == IDLE) && link_layer_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (send_req) begin
          state_nxt = WRITE_H2D_REG;
        end else if (rx.read_start) begin
          state_nxt = CHECK_FIS_TYPE;
        end
      end
      CHECK_FIS_TYPE: begin
        if (rx.read_finished) begin
          state_nxt = IDLE;
        end else if (hdr_cycle) begin
          // Unknown types wait here for the end of the frame
          case (hdr_type)
            `ST_FIS_D2H_REG:      state_nxt = READ_D2H_REG;
            `ST_FIS_SET_DEV_BITS: state_nxt = FINISH_SDB;
            `ST_FIS_DMA_ACT:      state_nxt = FINISH_DMA_ACT;
            default:              state_nxt = CHECK_FIS_TYPE;
          endcase
        end
      end
      WRITE_H2D_REG: begin
        if (write_done) begin
          state_nxt = tx_status.xmit_error ? RETRY : IDLE;
        end
      end
      RETRY: begin
        if (link_layer_ready) begin
          state_nxt = WRITE_H2D_REG;
        end
      end
      READ_D2H_REG, FINISH_SDB, FINISH_DMA_ACT: begin
        if (rx.read_finished) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
    if (sync_escape) begin
      state_nxt = IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state               <= IDLE;
      hdr_seen            <= 1'b0;
      cur_type            <= '0;
      write_start         <= 1'b0;
      d2h_reg_stb         <= 1'b0;
      set_device_bits_stb <= 1'b0;
      dma_activate_stb    <= 1'b0;
      remote_abort        <= 1'b0;
      xmit_error          <= 1'b0;
    end else begin
      state               <= state_nxt;
      write_start         <= (send_req || resend) && !sync_escape;
      remote_abort        <= ll_remote_abort;
      d2h_reg_stb         <= frame_end && (frame_type == `ST_FIS_D2H_REG);
      set_device_bits_stb <= frame_end && (frame_type == `ST_FIS_SET_DEV_BITS);
      dma_activate_stb    <= frame_end && (frame_type == `ST_FIS_DMA_ACT);

      if (state == IDLE) begin
        hdr_seen <= 1'b0;
        cur_type <= '0;
      end else if (hdr_cycle) begin
        hdr_seen <= 1'b1;
        cur_type <= hdr_type;
      end

      // Error stays up until the next request or a clean finish
      if (send_req || (write_done && !tx_status.xmit_error)) begin
        xmit_error <= 1'b0;
      end else if (write_done) begin
        xmit_error <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sata_transport_top.sv ====
// SATA transport layer top
`default_nettype none
`timescale 1ns/1ps

`include "sata_transport_macros.svh"

module sata_transport_top (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire sata_transport_pkg::h2d_regs_t     h2d,
  input  wire                                   send_command_stb,
  input  wire                                   send_control_stb,
  output sata_transport_pkg::d2h_regs_t          d2h,
  output logic                                  d2h_reg_stb,
  output logic                                  set_device_bits_stb,
  output logic                                  dma_activate_stb,
  output logic                                  remote_abort,
  output logic                                  xmit_error,
  output logic                                  transport_layer_ready,
  input  wire                                   link_layer_ready,
  input  wire                                   sync_escape,
  input  wire                                   ll_remote_abort,
  output sata_transport_pkg::ll_tx_t             tx,
  input  wire sata_transport_pkg::ll_tx_status_t tx_status,
  input  wire sata_transport_pkg::ll_rx_t        rx
);
  import sata_transport_pkg::*;

  logic       cnt_clear;
  logic       cnt_step;
  logic       capture;
  logic       cmd_bit;
  logic       write_start;
  dword_idx_t idx;
  fis_kind_t  fis_kind;
  dword_t     write_data;

  // Register frames are always five dwords long
  assign tx = '{write_start: write_start,
                write_data:  write_data,
                write_size:  dword_t'(`ST_H2D_REG_DWORDS)};

  transport_ctrl_fsm fsm_i (
    .clk                   (clk),
    .rst                   (rst),
    .send_command_stb      (send_command_stb),
    .send_control_stb      (send_control_stb),
    .link_layer_ready      (link_layer_ready),
    .sync_escape           (sync_escape),
    .ll_remote_abort       (ll_remote_abort),
    .tx_status             (tx_status),
    .rx                    (rx),
    .idx                   (idx),
    .cnt_clear             (cnt_clear),
    .cnt_step              (cnt_step),
    .capture               (capture),
    .cmd_bit               (cmd_bit),
    .write_start           (write_start),
    .fis_kind              (fis_kind),
    .d2h_reg_stb           (d2h_reg_stb),
    .set_device_bits_stb   (set_device_bits_stb),
    .dma_activate_stb      (dma_activate_stb),
    .remote_abort          (remote_abort),
    .xmit_error            (xmit_error),
    .transport_layer_ready (transport_layer_ready)
  );

  fis_dword_counter counter_i (
    .clk   (clk),
    .rst   (rst),
    .clear (cnt_clear),
    .step  (cnt_step),
    .idx   (idx)
  );

  h2d_fis_builder builder_i (
    .clk        (clk),
    .rst        (rst),
    .capture    (capture),
    .cmd_bit    (cmd_bit),
    .h2d        (h2d),
    .idx        (idx),
    .write_data (write_data)
  );

  d2h_fis_parser parser_i (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .idx      (idx),
    .fis_kind (fis_kind),
    .d2h      (d2h)
  );

endmodule

`default_nettype wire

// ==== verification/sata_transport_checker.sv ====
// Transport layer scoreboard
`default_nettype none
`timescale 1ns/1ps

`include "sata_transport_macros.svh"

module sata_transport_checker (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire sata_transport_pkg::h2d_regs_t     h2d,
  input  wire                                   send_command_stb,
  input  wire                                   send_control_stb,
  input  wire sata_transport_pkg::d2h_regs_t     d2h,
  input  wire [2:0]                             fis_stb,
  input  wire [1:0]                             exp_stb,
  input  wire                                   xmit_error,
  input  wire                                   remote_abort,
  input  wire                                   ll_remote_abort,
  input  wire                                   transport_layer_ready,
  input  wire                                   sync_escape,
  input  wire sata_transport_pkg::ll_tx_t        tx,
  input  wire sata_transport_pkg::ll_tx_status_t tx_status,
  input  wire sata_transport_pkg::ll_rx_t        rx,
  output int                                    checks,
  output int                                    errors
);
  import sata_transport_pkg::*;

  dword_t    exp_dw [0:4];
  dword_t    rx_buf [0:4];
  d2h_regs_t model;
  int        wr_idx;
  int        rx_cnt;
  int        starts;
  int        err_ends;
  logic      busy;
  logic      stb_due;
  logic      xerr_due;
  logic      xerr_exp;
  logic      abort_q;
  logic [2:0] stb_exp;

  task automatic compare(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("At %0t: %s", $time, msg);
  endtask

  // Register FIS layout, type in the low byte of dword 0
  task automatic capture_expected(input h2d_regs_t r, input logic c);
    exp_dw[0] = dword_t'(`ST_FIS_H2D_REG) | (dword_t'(r.port_mult) << 8) |
                (dword_t'(c) << 15) | (dword_t'(r.command) << 16) |
                (dword_t'(r.features[7:0]) << 24);
    exp_dw[1] = dword_t'(r.lba[23:0]) | (dword_t'(r.device) << 24);
    exp_dw[2] = dword_t'(r.lba[47:24]) | (dword_t'(r.features[15:8]) << 24);
    exp_dw[3] = dword_t'(r.sector_count) | (dword_t'(r.control) << 24);
    exp_dw[4] = '0;
  endtask

  // Device register image after a completed frame
  task automatic apply_frame();
    case (rx_buf[0][7:0])
      `ST_FIS_D2H_REG: begin
        model.error        = rx_buf[0][31:24];
        model.status       = rx_buf[0][23:16];
        model.interrupt    = rx_buf[0][14];
        model.port_mult    = rx_buf[0][11:8];
        model.device       = rx_buf[1][31:24];
        model.lba          = {rx_buf[2][23:0], rx_buf[1][23:0]};
        model.sector_count = rx_buf[3][15:0];
      end
      `ST_FIS_SET_DEV_BITS: begin
        model.error        = rx_buf[0][31:24];
        model.status       = (model.status & 8'h88) | (rx_buf[0][23:16] & 8'h77);
        model.notification = rx_buf[0][15];
        model.interrupt    = rx_buf[0][14];
        model.port_mult    = rx_buf[0][11:8];
      end
      default: begin
      end
    endcase
  endtask

  always @(posedge clk) begin
    if (rst) begin
      checks   = 0;
      errors   = 0;
      model    = '0;
      busy     = 1'b0;
      stb_due  = 1'b0;
      xerr_due = 1'b0;
      abort_q  = 1'b0;
      wr_idx   = 0;
      rx_cnt   = 0;
      starts   = 0;
      err_ends = 0;
    end else begin
      // Strobes may only appear in the cycle after a frame end
      compare("fis_strobes", fis_stb, stb_due ? stb_exp : 3'b000);
      if (stb_due) begin
        compare("d2h", d2h, model);
      end
      stb_due = 1'b0;
      if (xerr_due) begin
        compare("xmit_error", xmit_error, xerr_exp);
      end
      xerr_due = 1'b0;
      // Remote abort follows the link once its input has settled
      if (ll_remote_abort == abort_q) begin
        compare("remote_abort", remote_abort, ll_remote_abort);
      end
      abort_q = ll_remote_abort;
      if (busy && transport_layer_ready) begin
        report("transport_layer_ready rose before the send completed");
      end

      if (sync_escape) begin
        busy     = 1'b0;
        wr_idx   = 0;
        rx_cnt   = 0;
        starts   = 0;
        err_ends = 0;
      end else begin
        if ((send_command_stb || send_control_stb) && transport_layer_ready) begin
          capture_expected(h2d, send_command_stb);
          busy     = 1'b1;
          starts   = 0;
          err_ends = 0;
        end
        if (tx.write_start) begin
          compare("write_size", tx.write_size, `ST_H2D_REG_DWORDS);
          wr_idx = 0;
          starts++;
        end
        if (tx_status.write_strobe) begin
          if (wr_idx < `ST_H2D_REG_DWORDS) begin
            compare("write_data", tx.write_data, exp_dw[wr_idx]);
          end else begin
            report("write_strobe arrived past the end of the frame");
          end
          wr_idx++;
        end
        if (tx_status.write_finished) begin
          xerr_due = 1'b1;
          xerr_exp = tx_status.xmit_error;
          if (tx_status.xmit_error) begin
            err_ends++;
          end else begin
            if (starts != err_ends + 1) begin
              report("number of write_start pulses does not match the attempts");
            end
            busy = 1'b0;
          end
        end

        if (rx.read_start) begin
          rx_cnt = 0;
        end
        if (rx.read_strobe) begin
          if (rx_cnt < 5) begin
            rx_buf[rx_cnt] = rx.read_data;
          end
          rx_cnt++;
        end
        if (rx.read_finished) begin
          apply_frame();
          stb_due = 1'b1;
          case (exp_stb)
            2'd1: stb_exp = 3'b100;
            2'd2: stb_exp = 3'b010;
            2'd3: stb_exp = 3'b001;
            default: stb_exp = 3'b000;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_sata_transport.sv ====
// SATA transport testbench
`default_nettype none
`timescale 1ns/1ps

module tb_sata_transport;
  import sata_transport_pkg::*;

  localparam PATTERN_FILE = "verification/sata_transport_patterns.txt";

  typedef struct packed {
    logic             recv;
    h2d_regs_t        regs;
    logic             c_bit;
    // 0 clean, 1 transmit error then retry, 2 sync escape midway
    logic [1:0]       mode;
    logic [4:0][31:0] dw;
    logic [1:0]       stb;
  } op_t;

  logic          clk;
  logic          rst;
  h2d_regs_t     h2d;
  logic          send_command_stb;
  logic          send_control_stb;
  d2h_regs_t     d2h;
  logic          d2h_reg_stb;
  logic          set_device_bits_stb;
  logic          dma_activate_stb;
  logic          remote_abort;
  logic          xmit_error;
  logic          transport_layer_ready;
  logic          link_layer_ready;
  logic          sync_escape;
  logic          ll_remote_abort;
  ll_tx_t        tx;
  ll_tx_status_t tx_status;
  ll_rx_t        rx;
  logic [1:0]    exp_stb;
  int            checks;
  int            errors;
  op_t           ops[$];
  logic          load_error;
  int unsigned   dword_total;
  int unsigned   cycles = 0;
  int unsigned   cycle_limit;
  logic [31:0]   lcg_state;

  always #5 clk = ~clk;

  // Run limit from the pattern length
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  sata_transport_top dut_i (
    .clk                   (clk),
    .rst                   (rst),
    .h2d                   (h2d),
    .send_command_stb      (send_command_stb),
    .send_control_stb      (send_control_stb),
    .d2h                   (d2h),
    .d2h_reg_stb           (d2h_reg_stb),
    .set_device_bits_stb   (set_device_bits_stb),
    .dma_activate_stb      (dma_activate_stb),
    .remote_abort          (remote_abort),
    .xmit_error            (xmit_error),
    .transport_layer_ready (transport_layer_ready),
    .link_layer_ready      (link_layer_ready),
    .sync_escape           (sync_escape),
    .ll_remote_abort       (ll_remote_abort),
    .tx                    (tx),
    .tx_status             (tx_status),
    .rx                    (rx)
  );

  sata_transport_checker checker_i (
    .clk                   (clk),
    .rst                   (rst),
    .h2d                   (h2d),
    .send_command_stb      (send_command_stb),
    .send_control_stb      (send_control_stb),
    .d2h                   (d2h),
    .fis_stb               ({d2h_reg_stb, set_device_bits_stb, dma_activate_stb}),
    .exp_stb               (exp_stb),
    .xmit_error            (xmit_error),
    .remote_abort          (remote_abort),
    .ll_remote_abort       (ll_remote_abort),
    .transport_layer_ready (transport_layer_ready),
    .sync_escape           (sync_escape),
    .tx                    (tx),
    .tx_status             (tx_status),
    .rx                    (rx),
    .checks                (checks),
    .errors                (errors)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Link layer idles 0 to 3 cycles between strobes
  // and toggles its remote abort line now and then
  task automatic random_gap();
    logic [31:0] r;
    r = next_rand();
    ll_remote_abort = r[28];
    repeat (r[17:16]) @(negedge clk);
  endtask

  task automatic wait_ready();
    while (!transport_layer_ready) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_write_start();
    while (!tx.write_start) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic pulse_write_strobes(input int n);
    for (int i = 0; i < n; i++) begin
      random_gap();
      tx_status.write_strobe = 1'b1;
      @(negedge clk);
      tx_status.write_strobe = 1'b0;
    end
  endtask

  task automatic finish_write(input logic err);
    random_gap();
    tx_status.write_finished = 1'b1;
    tx_status.xmit_error     = err;
    @(negedge clk);
    tx_status.write_finished = 1'b0;
    tx_status.xmit_error     = 1'b0;
  endtask

  task automatic run_send(input op_t op);
    logic [31:0] r;
    wait_ready();
    h2d              = op.regs;
    send_command_stb = op.c_bit;
    send_control_stb = !op.c_bit;
    @(negedge clk);
    send_command_stb = 1'b0;
    send_control_stb = 1'b0;
    // Host scribbles over its registers while the frame is in flight
    r   = next_rand();
    h2d = {r[11:0], r, ~r, r};
    wait_write_start();
    if (op.mode == 2'd2) begin
      pulse_write_strobes(2);
      sync_escape = 1'b1;
      @(negedge clk);
      sync_escape = 1'b0;
    end else begin
      pulse_write_strobes(5);
      finish_write(op.mode == 2'd1);
      if (op.mode == 2'd1) begin
        link_layer_ready = 1'b0;
        repeat (3) @(negedge clk);
        link_layer_ready = 1'b1;
        wait_write_start();
        pulse_write_strobes(5);
        finish_write(1'b0);
      end
    end
  endtask

  task automatic run_recv(input op_t op);
    wait_ready();
    exp_stb       = op.stb;
    rx.read_start = 1'b1;
    @(negedge clk);
    rx.read_start = 1'b0;
    if (op.mode == 2'd2) begin
      random_gap();
      sync_escape = 1'b1;
      @(negedge clk);
      sync_escape = 1'b0;
    end else begin
      for (int i = 0; i < 5; i++) begin
        random_gap();
        rx.read_strobe = 1'b1;
        rx.read_data   = op.dw[i];
        @(negedge clk);
        rx.read_strobe = 1'b0;
      end
      random_gap();
      rx.read_finished = 1'b1;
      @(negedge clk);
      rx.read_finished = 1'b0;
    end
  endtask

  task automatic read_patterns();
    int            fd;
    int            r;
    logic [63:0]   tok;
    logic [47:0]   f [0:8];
    logic [31:0]   d [0:4];
    logic [2047:0] line;
    op_t           op;
    load_error  = 1'b0;
    dword_total = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      load_error = 1'b1;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        op = '0;
        if (tok == "#") begin
          r = $fgets(line, fd);
        end else if (tok == "SEND") begin
          r = $fscanf(fd, "%h %h %h %h %h %h %h %d %d",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
          if (r != 9) begin
            load_error = 1'b1;
          end
          op.regs.command      = f[0][7:0];
          op.regs.features     = f[1][15:0];
          op.regs.control      = f[2][7:0];
          op.regs.port_mult    = f[3][3:0];
          op.regs.device       = f[4][7:0];
          op.regs.lba          = f[5];
          op.regs.sector_count = f[6][15:0];
          op.c_bit             = f[7][0];
          op.mode              = f[8][1:0];
          ops.push_back(op);
          dword_total += (op.mode == 2'd1) ? 10 : 5;
        end else if (tok == "RECV") begin
          r = $fscanf(fd, "%h %h %h %h %h %s", d[0], d[1], d[2], d[3], d[4], tok);
          if (r != 6) begin
            load_error = 1'b1;
          end
          op.recv = 1'b1;
          for (int i = 0; i < 5; i++) begin
            op.dw[i] = d[i];
          end
          if (tok == "D2H") begin
            op.stb = 2'd1;
          end else if (tok == "SDB") begin
            op.stb = 2'd2;
          end else if (tok == "DMA") begin
            op.stb = 2'd3;
          end else if (tok == "ESC") begin
            op.mode = 2'd2;
          end else if (tok != "NONE") begin
            load_error = 1'b1;
          end
          ops.push_back(op);
          dword_total += 5;
        end else begin
          load_error = 1'b1;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    h2d              = '0;
    send_command_stb = 1'b0;
    send_control_stb = 1'b0;
    link_layer_ready = 1'b1;
    sync_escape      = 1'b0;
    ll_remote_abort  = 1'b0;
    tx_status        = '0;
    rx               = '0;
    exp_stb          = 2'd0;
    lcg_state        = 32'h301d;
    cycle_limit      = 32'hffff_ffff;
    read_patterns();
    cycle_limit = dword_total * 8 + 200;
    if (load_error || (ops.size() == 0)) begin
      $display("Pattern file could not be opened or holds a malformed line");
      $display("Regression failed");
    end else begin
      repeat (16) @(negedge clk);
      rst = 1'b0;
      foreach (ops[i]) begin
        if (ops[i].recv) begin
          run_recv(ops[i]);
        end else begin
          run_send(ops[i]);
        end
      end
      wait_ready();
      repeat (4) @(negedge clk);
      $display("Operations: %0d  Checks: %0d  Errors: %0d", ops.size(), checks, errors);
      if ((errors == 0) && (checks > 0)) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sata_transport.f ====
+incdir+include
rtl/sata_transport_pkg.sv
rtl/fis_dword_counter.sv
rtl/h2d_fis_builder.sv
rtl/d2h_fis_parser.sv
rtl/transport_ctrl_fsm.sv
rtl/sata_transport_top.sv
verification/sata_transport_checker.sv
verification/tb_sata_transport.sv

// ==== Bender.yml ====
package:
  name: sata_transport

sources:
  - include_dirs:
      - include
    files:
      - rtl/sata_transport_pkg.sv
      - rtl/fis_dword_counter.sv
      - rtl/h2d_fis_builder.sv
      - rtl/d2h_fis_parser.sv
      - rtl/transport_ctrl_fsm.sv
      - rtl/sata_transport_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/sata_transport_checker.sv
      - verification/tb_sata_transport.sv

// ==== verification/sata_transport_patterns.txt ====
# SEND command features control port_mult device lba sector_count c_bit mode (0 ok, 1 xerr, 2 escape)
# RECV dword0 dword1 dword2 dword3 dword4 strobe (D2H, SDB, DMA, NONE, ESC)
SEND 25 0001 00 0 40 000012345678 0008 1 0
SEND 00 0000 04 0 00 000000000000 0000 0 0
SEND ca 1234 00 5 e0 abcdef012345 0100 1 1
SEND 35 00ff 00 2 40 00000000beef 0020 1 2
RECV 00504134 40123456 00789abc 00000010 00000000 D2H
RECV 0451c3a1 deadbeef 00000000 00000000 00000000 SDB
RECV 00000039 00000000 00000000 00000000 00000000 DMA
RECV 00000046 11111111 22222222 33333333 44444444 NONE
RECV 01ff4234 e0aabbcc 00ddeeff 0000ffff 00000000 D2H
RECV 000040a1 00000000 00000000 00000000 00000000 SDB
RECV 00504134 55555555 66666666 77777777 88888888 ESC
SEND ef 0003 08 f 00 000000000000 0000 0 1
SEND 60 0100 00 1 40 0000fedcba98 0001 1 0
RECV 00000027 00000000 00000000 00000000 00000000 NONE
